// File: Makefile
TOP := tb_dccm_ctl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f build.f --top-module dccm_ctl_top
	verilator --lint-only --timing --timescale 1ns/100ps -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+verilog
verilog/dccm_pkg.sv
verilog/lsu_store_issue.sv
verilog/lsu_store_buffer.sv
verilog/dccm_ram.sv
verilog/dccm_port_ctl.sv
verilog/lsu_load_align.sv
verilog/dccm_ctl_top.sv
tb/tb_dccm_ctl.sv

// File: tb/tb_dccm_ctl.sv
`include "dccm_consts.svh"

module tb_dccm_ctl;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 100;
   localparam int MAX_OPS    = 64;
   localparam int WAIT_LIMIT = 50;  // cycles before a wait gives up

   localparam int OP_ST   = 0;  // store
   localparam int OP_LD   = 1;  // load and check result
   localparam int OP_DMA  = 2;  // one dma word write
   localparam int OP_WAIT = 3;  // wait for stbuf_empty
   localparam int OP_HOLD = 4;  // raise dma_wen and keep it high
   localparam int OP_REL  = 5;  // check st_ready, then drop dma_wen

   logic        clk;
   logic        arst_n;
   logic        st_valid;
   logic [15:0] st_addr;
   logic [1:0]  st_size;
   logic [31:0] st_data;
   logic        ld_valid;
   logic [15:0] ld_addr;
   logic [1:0]  ld_size;
   logic        dma_wen;
   logic [13:0] dma_addr;
   logic [31:0] dma_wdata;
   logic        st_ready;
   logic        stbuf_empty;
   logic        ld_data_valid;
   logic [31:0] ld_data;

   int          op_kind [MAX_OPS];
   logic [15:0] op_addr [MAX_OPS];
   logic [1:0]  op_size [MAX_OPS];
   logic [31:0] op_data [MAX_OPS];
   logic [31:0] op_exp  [MAX_OPS];
   int          n_ops;
   logic        table_ready;

   logic [7:0]  ref_mem [0:65535];  // byte-wide reference memory
   logic [31:0] lcg_state;
   int          errors;
   int          n_checks;

   dccm_ctl_top u_dccm_ctl_top (
      .clk           (clk),
      .arst_n        (arst_n),
      .st_valid      (st_valid),
      .st_addr       (st_addr),
      .st_size       (st_size),
      .st_data       (st_data),
      .ld_valid      (ld_valid),
      .ld_addr       (ld_addr),
      .ld_size       (ld_size),
      .dma_wen       (dma_wen),
      .dma_addr      (dma_addr),
      .dma_wdata     (dma_wdata),
      .st_ready      (st_ready),
      .stbuf_empty   (stbuf_empty),
      .ld_data_valid (ld_data_valid),
      .ld_data       (ld_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic void add_op(input int kind, input logic [15:0] addr,
                                  input logic [1:0] size);
      op_kind[n_ops] = kind;
      op_addr[n_ops] = addr;
      op_size[n_ops] = size;
      op_data[n_ops] = '0;
      op_exp[n_ops]  = '0;
      n_ops++;
   endfunction

   function automatic void model_write(input logic [15:0] addr, input logic [1:0] size,
                                       input logic [31:0] data);
      for (int b = 0; b < (1 << size); b++) begin
         ref_mem[int'(addr) + b] = data[8*b +: 8];  // little endian
      end
   endfunction

   function automatic logic [31:0] model_read(input logic [15:0] addr,
                                              input logic [1:0] size);
      logic [31:0] val;
      val = '0;  // zero-extended
      for (int b = 0; b < (1 << size); b++) begin
         val[8*b +: 8] = ref_mem[int'(addr) + b];
      end
      return val;
   endfunction

   function automatic void build_table();
      // sizes of each kind settled by wait-empty
      add_op(OP_ST, 16'h0100, 2'd2);
      add_op(OP_ST, 16'h0104, 2'd0);
      add_op(OP_ST, 16'h0105, 2'd0);
      add_op(OP_ST, 16'h0106, 2'd1);
      add_op(OP_ST, 16'h0108, 2'd2);
      add_op(OP_WAIT, 16'h0000, 2'd0);
      add_op(OP_LD, 16'h0100, 2'd0);
      add_op(OP_LD, 16'h0101, 2'd0);
      add_op(OP_LD, 16'h0102, 2'd0);
      add_op(OP_LD, 16'h0103, 2'd0);
      add_op(OP_LD, 16'h0100, 2'd1);
      add_op(OP_LD, 16'h0102, 2'd1);
      add_op(OP_LD, 16'h0100, 2'd2);
      add_op(OP_LD, 16'h0104, 2'd2);
      add_op(OP_LD, 16'h0107, 2'd0);
      // loads right behind stores to the same word
      add_op(OP_ST, 16'h0200, 2'd2);
      add_op(OP_ST, 16'h0201, 2'd0);
      add_op(OP_LD, 16'h0200, 2'd2);
      add_op(OP_ST, 16'h0202, 2'd1);
      add_op(OP_LD, 16'h0202, 2'd1);
      add_op(OP_WAIT, 16'h0000, 2'd0);
      add_op(OP_ST, 16'h0203, 2'd0);
      add_op(OP_LD, 16'h0200, 2'd2);  // three bytes memory, one forwarded
      // dma word while other stores are queued
      add_op(OP_ST, 16'h0300, 2'd2);
      add_op(OP_ST, 16'h0306, 2'd1);
      add_op(OP_DMA, 16'h0400, 2'd2);
      add_op(OP_LD, 16'h0400, 2'd2);
      add_op(OP_LD, 16'h0402, 2'd1);
      add_op(OP_WAIT, 16'h0000, 2'd0);
      add_op(OP_LD, 16'h0300, 2'd2);
      add_op(OP_LD, 16'h0306, 2'd1);
      // dma held high fills the buffer
      add_op(OP_HOLD, 16'h0500, 2'd2);
      add_op(OP_ST, 16'h0600, 2'd2);
      add_op(OP_ST, 16'h0602, 2'd1);
      add_op(OP_ST, 16'h060a, 2'd1);
      add_op(OP_ST, 16'h060c, 2'd2);
      add_op(OP_LD, 16'h0600, 2'd2);  // younger half overrides the older word
      add_op(OP_REL, 16'h0000, 2'd0);
      add_op(OP_WAIT, 16'h0000, 2'd0);
      add_op(OP_LD, 16'h0600, 2'd2);
      add_op(OP_LD, 16'h0602, 2'd1);
      add_op(OP_LD, 16'h060a, 2'd1);
      add_op(OP_LD, 16'h060c, 2'd2);
      add_op(OP_LD, 16'h0500, 2'd2);
   endfunction

   // program order model that fills data and expected values
   function automatic void compute_expected();
      int held_stores;
      logic held;
      held_stores = 0;
      held        = 1'b0;
      for (int i = 0; i < n_ops; i++) begin
         case (op_kind[i])
            OP_ST: begin
               op_data[i] = lcg_next();
               model_write(op_addr[i], op_size[i], op_data[i]);
               if (held) begin
                  held_stores++;
               end
            end
            OP_LD: op_exp[i] = model_read(op_addr[i], op_size[i]);
            OP_DMA, OP_HOLD: begin
               op_data[i] = lcg_next();
               model_write(op_addr[i], 2'd2, op_data[i]);
               held        = (op_kind[i] == OP_HOLD);
               held_stores = 0;
            end
            OP_REL: begin
               op_exp[i] = (held_stores < `STBUF_DEPTH) ? 32'd1 : 32'd0;
               held      = 1'b0;
            end
            default: ;
         endcase
      end
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   // ld_data_valid must follow a load by exactly one cycle
   task automatic next_cycle();
      logic was_load;
      was_load = ld_valid;
      @(negedge clk);
      compare_value("ld_data_valid", ld_data_valid, was_load);
   endtask

   task automatic do_store(input logic [15:0] addr, input logic [1:0] size,
                           input logic [31:0] data);
      int waits;
      waits    = 0;
      st_valid = 1'b1;
      st_addr  = addr;
      st_size  = size;
      st_data  = data;
      while (!st_ready && (waits < WAIT_LIMIT)) begin
         next_cycle();
         waits++;
      end
      if (!st_ready) begin
         errors++;
         $display("store to address %h was never accepted", addr);
      end
      next_cycle();
      st_valid = 1'b0;
   endtask

   task automatic do_load(input logic [15:0] addr, input logic [1:0] size,
                          input logic [31:0] exp);
      ld_valid = 1'b1;
      ld_addr  = addr;
      ld_size  = size;
      next_cycle();
      compare_value("ld_data", ld_data, exp);
      ld_valid = 1'b0;
   endtask

   task automatic wait_drained();
      int waits;
      waits = 0;
      while (!stbuf_empty && (waits < WAIT_LIMIT)) begin
         next_cycle();
         waits++;
      end
      if (!stbuf_empty) begin
         errors++;
         $display("store buffer did not drain within %0d cycles", WAIT_LIMIT);
      end
      compare_value("st_ready", st_ready, 32'd1);
      compare_value("stbuf_empty", stbuf_empty, 32'd1);
   endtask

   initial begin
      lcg_state   = 32'h74e3ba86;
      n_ops       = 0;
      errors      = 0;
      n_checks    = 0;
      table_ready = 1'b0;
      arst_n      = 1'b0;
      st_valid    = 1'b0;
      st_addr     = '0;
      st_size     = '0;
      st_data     = '0;
      ld_valid    = 1'b0;
      ld_addr     = '0;
      ld_size     = '0;
      dma_wen     = 1'b0;
      dma_addr    = '0;
      dma_wdata   = '0;
      build_table();
      compute_expected();
      table_ready = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      compare_value("st_ready", st_ready, 32'd1);
      compare_value("stbuf_empty", stbuf_empty, 32'd1);
      compare_value("ld_data_valid", ld_data_valid, 32'd0);
      arst_n = 1'b1;
      for (int i = 0; i < n_ops; i++) begin
         case (op_kind[i])
            OP_ST:   do_store(op_addr[i], op_size[i], op_data[i]);
            OP_LD:   do_load(op_addr[i], op_size[i], op_exp[i]);
            OP_WAIT: wait_drained();
            OP_REL: begin
               compare_value("st_ready", st_ready, op_exp[i]);
               dma_wen = 1'b0;
            end
            default: begin  // dma single or held
               dma_wen   = 1'b1;
               dma_addr  = op_addr[i][15:2];
               dma_wdata = op_data[i];
               next_cycle();
               dma_wen   = (op_kind[i] == OP_HOLD);
            end
         endcase
      end
      next_cycle();
      $display("checks %0d, errors %0d", n_checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      wait (table_ready);
      #(n_ops * 20 * CLK_PERIOD);
      $display("timeout, the operation table did not finish in %0d cycles", n_ops * 20);
      $display("test failed");
      $finish;
   end

endmodule

// File: verilog/dccm_consts.svh
`ifndef DCCM_CONSTS_SVH
`define DCCM_CONSTS_SVH

`define DCCM_ADDR_W   16  // byte address
`define DCCM_WORD_AW  14  // word index, 16k words
`define DCCM_DATA_W   32
`define DCCM_BYTES    4   // bytes per word

`define STBUF_DEPTH   4
`define STBUF_PTR_W   2
`define STBUF_CNT_W   3   // must hold 0..STBUF_DEPTH

`endif

// File: verilog/dccm_ctl_top.sv
`include "dccm_consts.svh"

module dccm_ctl_top
   import dccm_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         st_valid,
   input  byte_addr_t   st_addr,
   input  access_size_t st_size,
   input  data_word_t   st_data,
   input  logic         ld_valid,
   input  byte_addr_t   ld_addr,
   input  access_size_t ld_size,
   input  logic         dma_wen,
   input  word_addr_t   dma_addr,
   input  data_word_t   dma_wdata,
   output logic         st_ready,
   output logic         stbuf_empty,
   output logic         ld_data_valid,
   output data_word_t   ld_data
);

   logic       push;
   word_addr_t push_addr;
   data_word_t push_data;
   byte_en_t   push_be;
   logic       credit_return;
   logic       drain_req;
   word_addr_t drain_addr;
   data_word_t drain_data;
   byte_en_t   drain_be;
   logic       drain_grant;
   data_word_t fwd_data;
   byte_en_t   fwd_be;
   data_word_t rd_data;

   lsu_store_issue u_lsu_store_issue (
      .clk           (clk),
      .arst_n        (arst_n),
      .st_valid      (st_valid),
      .st_addr       (st_addr),
      .st_size       (st_size),
      .st_data       (st_data),
      .credit_return (credit_return),
      .st_ready      (st_ready),
      .push          (push),
      .push_addr     (push_addr),
      .push_data     (push_data),
      .push_be       (push_be)
   );

   lsu_store_buffer u_lsu_store_buffer (
      .clk           (clk),
      .arst_n        (arst_n),
      .push          (push),
      .push_addr     (push_addr),
      .push_data     (push_data),
      .push_be       (push_be),
      .drain_grant   (drain_grant),
      .ld_addr       (ld_addr),
      .drain_req     (drain_req),
      .drain_addr    (drain_addr),
      .drain_data    (drain_data),
      .drain_be      (drain_be),
      .credit_return (credit_return),
      .fwd_data      (fwd_data),
      .fwd_be        (fwd_be),
      .stbuf_empty   (stbuf_empty)
   );

   dccm_port_ctl u_dccm_port_ctl (
      .clk         (clk),
      .arst_n      (arst_n),
      .ld_valid    (ld_valid),
      .ld_addr     (ld_addr),
      .dma_wen     (dma_wen),
      .dma_addr    (dma_addr),
      .dma_wdata   (dma_wdata),
      .drain_req   (drain_req),
      .drain_addr  (drain_addr),
      .drain_data  (drain_data),
      .drain_be    (drain_be),
      .drain_grant (drain_grant),
      .rd_data     (rd_data)
   );

   lsu_load_align u_lsu_load_align (
      .clk           (clk),
      .arst_n        (arst_n),
      .ld_valid      (ld_valid),
      .ld_addr       (ld_addr),
      .ld_size       (ld_size),
      .fwd_data      (fwd_data),
      .fwd_be        (fwd_be),
      .rd_data       (rd_data),
      .ld_data_valid (ld_data_valid),
      .ld_data       (ld_data)
   );

endmodule

// File: verilog/dccm_pkg.sv
`include "dccm_consts.svh"

package dccm_pkg;

   typedef logic [`DCCM_ADDR_W-1:0]  byte_addr_t;
   typedef logic [`DCCM_WORD_AW-1:0] word_addr_t;
   typedef logic [`DCCM_DATA_W-1:0]  data_word_t;
   typedef logic [`DCCM_BYTES-1:0]   byte_en_t;

   // 0 byte, 1 half, 2 word
   typedef logic [1:0] access_size_t;

   typedef logic [`STBUF_CNT_W-1:0] credit_cnt_t;  // credits and buffer occupancy

endpackage

// File: verilog/dccm_port_ctl.sv
`include "dccm_consts.svh"

module dccm_port_ctl
   import dccm_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       ld_valid,
   input  byte_addr_t ld_addr,
   input  logic       dma_wen,
   input  word_addr_t dma_addr,
   input  data_word_t dma_wdata,
   input  logic       drain_req,
   input  word_addr_t drain_addr,
   input  data_word_t drain_data,
   input  byte_en_t   drain_be,
   output logic       drain_grant,
   output data_word_t rd_data
);

   word_addr_t ld_word;
   logic       ld_hits_head;
   logic       ram_wen;
   word_addr_t ram_waddr;
   data_word_t ram_wdata;
   byte_en_t   ram_wbe;
   data_word_t ram_rdata;
   logic       rd_vld_q;

   assign ld_word      = ld_addr[`DCCM_ADDR_W-1:2];
   assign ld_hits_head = ld_valid & (ld_word == drain_addr);

   // dma first, then a drain that does not collide with the load
   assign drain_grant = drain_req & ~dma_wen & ~ld_hits_head;

   assign ram_wen   = dma_wen | drain_grant;
   assign ram_waddr = dma_wen ? dma_addr : drain_addr;
   assign ram_wdata = dma_wen ? dma_wdata : drain_data;
   assign ram_wbe   = dma_wen ? '1 : drain_be;  // dma writes whole words

   dccm_ram u_dccm_ram (
      .clk   (clk),
      .wen   (ram_wen),
      .waddr (ram_waddr),
      .wdata (ram_wdata),
      .wbe   (ram_wbe),
      .raddr (ld_word),
      .rdata (ram_rdata)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_vld_q <= 1'b0;
      end else begin
         rd_vld_q <= ld_valid;
      end
   end

   assign rd_data = rd_vld_q ? ram_rdata : '0;  // bus quiet between loads

endmodule

// File: verilog/dccm_ram.sv
`include "dccm_consts.svh"

module dccm_ram
   import dccm_pkg::*;
(
   input  logic       clk,
   input  logic       wen,
   input  word_addr_t waddr,
   input  data_word_t wdata,
   input  byte_en_t   wbe,
   input  word_addr_t raddr,
   output data_word_t rdata
);

   data_word_t mem [2**`DCCM_WORD_AW];

   always_ff @(posedge clk) begin
      if (wen) begin
         for (int b = 0; b < `DCCM_BYTES; b++) begin
            if (wbe[b]) begin
               mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
      end
      rdata <= mem[raddr];  // old data on a same-edge write
   end

endmodule

// File: verilog/lsu_load_align.sv
`include "dccm_consts.svh"

module lsu_load_align
   import dccm_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         ld_valid,
   input  byte_addr_t   ld_addr,
   input  access_size_t ld_size,
   input  data_word_t   fwd_data,
   input  byte_en_t     fwd_be,
   input  data_word_t   rd_data,
   output logic         ld_data_valid,
   output data_word_t   ld_data
);

   logic         vld_q;
   logic [1:0]   off_q;
   access_size_t size_q;
   data_word_t   fwd_data_q;
   byte_en_t     fwd_be_q;
   data_word_t   merged;
   data_word_t   shifted;
   data_word_t   size_mask;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= ld_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_valid) begin
         off_q      <= ld_addr[1:0];
         size_q     <= ld_size;
         fwd_data_q <= fwd_data;
         fwd_be_q   <= fwd_be;
      end
   end

   always_comb begin
      for (int b = 0; b < `DCCM_BYTES; b++) begin
         merged[8*b +: 8] = fwd_be_q[b] ? fwd_data_q[8*b +: 8] : rd_data[8*b +: 8];
      end
   end

   always_comb begin
      case (size_q)
         2'd0:    size_mask = 32'h0000_00ff;
         2'd1:    size_mask = 32'h0000_ffff;
         default: size_mask = 32'hffff_ffff;
      endcase
   end

   assign shifted       = merged >> {off_q, 3'b000};  // right-justify
   assign ld_data       = shifted & size_mask;        // zero-extend
   assign ld_data_valid = vld_q;

endmodule

// File: verilog/lsu_store_buffer.sv
`include "dccm_consts.svh"

module lsu_store_buffer
   import dccm_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       push,
   input  word_addr_t push_addr,
   input  data_word_t push_data,
   input  byte_en_t   push_be,
   input  logic       drain_grant,
   input  byte_addr_t ld_addr,
   output logic       drain_req,
   output word_addr_t drain_addr,
   output data_word_t drain_data,
   output byte_en_t   drain_be,
   output logic       credit_return,
   output data_word_t fwd_data,
   output byte_en_t   fwd_be,
   output logic       stbuf_empty
);

   word_addr_t ent_addr [`STBUF_DEPTH];
   data_word_t ent_data [`STBUF_DEPTH];
   byte_en_t   ent_be   [`STBUF_DEPTH];

   logic [`STBUF_PTR_W-1:0] wr_ptr;
   logic [`STBUF_PTR_W-1:0] rd_ptr;
   credit_cnt_t             count;
   logic                    pop;
   word_addr_t              ld_word;

   assign pop         = drain_grant & drain_req;
   assign stbuf_empty = (count == '0);
   assign drain_req   = ~stbuf_empty;
   assign drain_addr  = ent_addr[rd_ptr];  // head is the oldest store
   assign drain_data  = ent_data[rd_ptr];
   assign drain_be    = ent_be[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         ent_addr[wr_ptr] <= push_addr;
         ent_data[wr_ptr] <= push_data;
         ent_be[wr_ptr]   <= push_be;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         credit_return <= pop;  // one credit per drained entry
      end
   end

   assign ld_word = ld_addr[`DCCM_ADDR_W-1:2];

   // oldest first, so a younger store overwrites each byte it covers
   always_comb begin
      logic [`STBUF_PTR_W-1:0] idx;
      fwd_data = '0;
      fwd_be   = '0;
      idx      = rd_ptr;
      for (int i = 0; i < `STBUF_DEPTH; i++) begin
         idx = rd_ptr + `STBUF_PTR_W'(i);
         if ((credit_cnt_t'(i) < count) && (ent_addr[idx] == ld_word)) begin
            for (int b = 0; b < `DCCM_BYTES; b++) begin
               if (ent_be[idx][b]) begin
                  fwd_data[8*b +: 8] = ent_data[idx][8*b +: 8];
                  fwd_be[b]          = 1'b1;
               end
            end
         end
      end
   end

endmodule

// File: verilog/lsu_store_issue.sv
`include "dccm_consts.svh"

module lsu_store_issue
   import dccm_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         st_valid,
   input  byte_addr_t   st_addr,
   input  access_size_t st_size,
   input  data_word_t   st_data,
   input  logic         credit_return,
   output logic         st_ready,
   output logic         push,
   output word_addr_t   push_addr,
   output data_word_t   push_data,
   output byte_en_t     push_be
);

   credit_cnt_t credits;
   byte_en_t    base_be;
   logic [1:0]  offset;

   assign offset = st_addr[1:0];

   always_comb begin
      case (st_size)
         2'd0:    base_be = 4'b0001;
         2'd1:    base_be = 4'b0011;
         default: base_be = 4'b1111;
      endcase
   end

   assign push_be   = base_be << offset;
   assign push_data = st_data << {offset, 3'b000};  // byte lanes line up with the word
   assign push_addr = st_addr[`DCCM_ADDR_W-1:2];

   assign st_ready = (credits != '0);
   assign push     = st_valid & st_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credits <= credit_cnt_t'(`STBUF_DEPTH);  // buffer starts empty
      end else begin
         case ({push, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;  // both or neither cancel out
         endcase
      end
   end

endmodule
